// File: hdl/control_registers.sv
//############################################################
// Control register write decoder
// Holds the thread enable and counter enable registers,
// turns control register writes into counter clear and
// preload commands and gates raw events into increments.
//############################################################

`timescale 1ns/1ps

module control_registers (
	input  logic                                          clk,
	input  logic                                          arst_n,
	input  logic                                          creg_write_en,
	input  creg_pkg::control_register_t                   creg_index,
	input  logic [core_config_pkg::SCALAR_WIDTH-1:0]      creg_write_val,
	input  logic [core_config_pkg::NUM_COUNTERS-1:0]      perf_event,
	output logic [core_config_pkg::THREADS_PER_CORE-1:0]  thread_enable,
	output logic [core_config_pkg::NUM_COUNTERS-1:0]      perf_enable,
	output logic                                          processor_halt,
	output logic [core_config_pkg::NUM_COUNTERS-1:0]      count_inc,
	output logic [core_config_pkg::NUM_COUNTERS-1:0]      count_clear,
	output logic [core_config_pkg::NUM_COUNTERS-1:0]      count_load,
	output logic [core_config_pkg::COUNTER_WIDTH-1:0]     load_value
);

	logic [core_config_pkg::THREADS_PER_CORE-1:0] thread_mask;	// Thread bits of write
	logic [core_config_pkg::NUM_COUNTERS-1:0]     counter_mask;	// Counter bits of write

	assign thread_mask = creg_write_val[core_config_pkg::THREADS_PER_CORE-1:0];
	assign counter_mask = creg_write_val[core_config_pkg::NUM_COUNTERS-1:0];

	// Enable registers, written on the strobe edge
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			thread_enable <= core_config_pkg::RESET_THREAD_ENABLE;	// Thread 0 only
			perf_enable <= '1;	// All counters running
		end else if (creg_write_en) begin
			case (creg_index)
				creg_pkg::CR_THREAD_RESUME: begin
					thread_enable <= thread_enable | thread_mask;	// Start named threads
				end
				creg_pkg::CR_THREAD_HALT: begin
					thread_enable <= thread_enable & ~thread_mask;	// Stop named threads
				end
				creg_pkg::CR_PERF_ENABLE: begin
					perf_enable <= counter_mask;	// Replace whole mask
				end
				default: begin
				end	// Other indices leave enables alone
			endcase
		end
	end

	// Halted once the last thread drops out
	assign processor_halt = ~(|thread_enable);

	// Registered enable, so an event at the enable edge sees the old mask
	assign count_inc = perf_event & perf_enable;

	// Clear takes a mask, several counters at once
	assign count_clear = (creg_write_en && creg_index == creg_pkg::CR_PERF_CLEAR) ?
		counter_mask : '0;

	// Preload hits the one counter the index names
	always_comb begin
		count_load = '0;
		for (int i = 0; i < core_config_pkg::NUM_COUNTERS; i++) begin
			if (creg_write_en && creg_index == creg_pkg::CR_PERF_COUNT0 + i) begin
				count_load[i] = 1'b1;	// Consecutive counter codes
			end
		end
	end

	assign load_value = creg_write_val[core_config_pkg::COUNTER_WIDTH-1:0];	// Low bits only

endmodule

// File: hdl/core_config_pkg.sv
//############################################################
// Core configuration
// Sizes of the hardware thread set, the performance counter
// bank and the control register data path, plus the thread
// enable value the core comes out of reset with.
//############################################################

package core_config_pkg;

	// Thread set
	localparam int THREADS_PER_CORE = 4;	// Hardware threads per core

	// Performance monitor
	localparam int NUM_COUNTERS = 8;	// One counter per event line
	localparam int COUNTER_WIDTH = 16;	// Wraps at all ones

	// Control register data path
	localparam int SCALAR_WIDTH = 32;	// Width of a register value

	// Only thread 0 runs after reset, the rest wait for a resume
	localparam logic [THREADS_PER_CORE-1:0] RESET_THREAD_ENABLE =
		THREADS_PER_CORE'(1);

endpackage

// File: hdl/core_perf_control.sv
//############################################################
// Core control and performance monitor
// Connects the control register decoder, the bank of event
// counters and the registered read path.
//############################################################

`timescale 1ns/1ps

module core_perf_control #(
	parameter int core_id = 0
) (
	input  logic                                          clk,
	input  logic                                          arst_n,
	input  logic [core_config_pkg::NUM_COUNTERS-1:0]      perf_event,
	input  logic                                          creg_write_en,
	input  logic                                          creg_read_en,
	input  creg_pkg::control_register_t                   creg_index,
	input  logic [core_config_pkg::SCALAR_WIDTH-1:0]      creg_write_val,
	output logic [core_config_pkg::SCALAR_WIDTH-1:0]      creg_read_val,
	output logic                                          creg_read_valid,
	output logic [core_config_pkg::THREADS_PER_CORE-1:0]  thread_enable,
	output logic                                          processor_halt
);

	logic [core_config_pkg::NUM_COUNTERS-1:0]  perf_enable;	// Counter enable mask
	logic [core_config_pkg::NUM_COUNTERS-1:0]  count_inc;	// Gated events
	logic [core_config_pkg::NUM_COUNTERS-1:0]  count_clear;	// Clear mask
	logic [core_config_pkg::NUM_COUNTERS-1:0]  count_load;	// One-hot preload
	logic [core_config_pkg::COUNTER_WIDTH-1:0] load_value;	// Shared preload value
	logic [core_config_pkg::NUM_COUNTERS-1:0]
		[core_config_pkg::COUNTER_WIDTH-1:0]   counts;	// Counter bank values
	logic [core_config_pkg::NUM_COUNTERS-1:0]  overflows;	// Sticky wrap flags

	control_registers control_registers_i (
		.clk            (clk),
		.arst_n         (arst_n),
		.creg_write_en  (creg_write_en),
		.creg_index     (creg_index),
		.creg_write_val (creg_write_val),
		.perf_event     (perf_event),
		.thread_enable  (thread_enable),
		.perf_enable    (perf_enable),
		.processor_halt (processor_halt),
		.count_inc      (count_inc),
		.count_clear    (count_clear),
		.count_load     (count_load),
		.load_value     (load_value)
	);

	// One counter per event line
	for (genvar i = 0; i < core_config_pkg::NUM_COUNTERS; i++) begin : counter_gen
		perf_counter perf_counter_i (
			.clk        (clk),
			.arst_n     (arst_n),
			.inc        (count_inc[i]),
			.clear      (count_clear[i]),
			.load       (count_load[i]),
			.load_value (load_value),
			.count      (counts[i]),
			.overflow   (overflows[i])
		);
	end

	creg_read_mux #(
		.core_id (core_id)
	) creg_read_mux_i (
		.clk             (clk),
		.arst_n          (arst_n),
		.creg_read_en    (creg_read_en),
		.creg_index      (creg_index),
		.thread_enable   (thread_enable),
		.perf_enable     (perf_enable),
		.counts          (counts),
		.overflows       (overflows),
		.creg_read_val   (creg_read_val),
		.creg_read_valid (creg_read_valid)
	);

endmodule

// File: hdl/creg_pkg.sv
//############################################################
// Control register encodings
// Index codes of the core's control registers and the bit
// positions of the performance events on perf_event.
//############################################################

package creg_pkg;

	// Control register indices
	typedef enum logic [4:0] {
		CR_CORE_ID       = 5'd0,	// Read only
		CR_THREAD_ENABLE = 5'd1,	// Read only
		CR_THREAD_RESUME = 5'd2,	// Write sets thread bits
		CR_THREAD_HALT   = 5'd3,	// Write clears thread bits
		CR_PERF_ENABLE   = 5'd4,	// Counter enable mask
		CR_PERF_CLEAR    = 5'd5,	// Write clears masked counters
		CR_PERF_OVERFLOW = 5'd6,	// Sticky wrap flags
		CR_PERF_COUNT0   = 5'd8,	// Counter values, consecutive
		CR_PERF_COUNT1   = 5'd9,
		CR_PERF_COUNT2   = 5'd10,
		CR_PERF_COUNT3   = 5'd11,
		CR_PERF_COUNT4   = 5'd12,
		CR_PERF_COUNT5   = 5'd13,
		CR_PERF_COUNT6   = 5'd14,
		CR_PERF_COUNT7   = 5'd15
	} control_register_t;

	// Event bit positions, pipeline order
	typedef enum logic [2:0] {
		DCACHE_MISS        = 3'd0,
		DCACHE_HIT         = 3'd1,
		ICACHE_MISS        = 3'd2,
		ICACHE_HIT         = 3'd3,
		INSTRUCTION_ISSUE  = 3'd4,
		INSTRUCTION_RETIRE = 3'd5,
		STORE_COUNT        = 3'd6,
		STORE_ROLLBACK     = 3'd7
	} perf_event_t;

endpackage

// File: hdl/creg_read_mux.sv
//############################################################
// Control register read path
// Selects one control register or counter on a read strobe
// and returns it, zero extended, with a valid strobe on the
// following cycle.
//############################################################

`timescale 1ns/1ps

module creg_read_mux #(
	parameter int core_id = 0
) (
	input  logic                                          clk,
	input  logic                                          arst_n,
	input  logic                                          creg_read_en,
	input  creg_pkg::control_register_t                   creg_index,
	input  logic [core_config_pkg::THREADS_PER_CORE-1:0]  thread_enable,
	input  logic [core_config_pkg::NUM_COUNTERS-1:0]      perf_enable,
	input  logic [core_config_pkg::NUM_COUNTERS-1:0]
		[core_config_pkg::COUNTER_WIDTH-1:0]              counts,
	input  logic [core_config_pkg::NUM_COUNTERS-1:0]      overflows,
	output logic [core_config_pkg::SCALAR_WIDTH-1:0]      creg_read_val,
	output logic                                          creg_read_valid
);

	logic [core_config_pkg::SCALAR_WIDTH-1:0] read_sel;	// Decoded value

	// Index decode, everything zero extended
	always_comb begin
		read_sel = '0;	// Unknown and write only indices
		case (creg_index)
			creg_pkg::CR_CORE_ID: begin
				read_sel = core_id;
			end
			creg_pkg::CR_THREAD_ENABLE: begin
				read_sel[core_config_pkg::THREADS_PER_CORE-1:0] = thread_enable;
			end
			creg_pkg::CR_PERF_ENABLE: begin
				read_sel[core_config_pkg::NUM_COUNTERS-1:0] = perf_enable;
			end
			creg_pkg::CR_PERF_OVERFLOW: begin
				read_sel[core_config_pkg::NUM_COUNTERS-1:0] = overflows;
			end
			default: begin
			end
		endcase

		// Counter window, one code per counter
		for (int i = 0; i < core_config_pkg::NUM_COUNTERS; i++) begin
			if (creg_index == creg_pkg::CR_PERF_COUNT0 + i) begin
				read_sel[core_config_pkg::COUNTER_WIDTH-1:0] = counts[i];
			end
		end
	end

	// Valid follows the strobe by one edge
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			creg_read_valid <= 1'b0;
		end else begin
			creg_read_valid <= creg_read_en;	// One cycle per read
		end
	end

	// Data captured with the strobe, pre-write state
	always_ff @(posedge clk) begin
		if (creg_read_en) begin
			creg_read_val <= read_sel;
		end
	end

endmodule

// File: hdl/perf_counter.sv
//############################################################
// Performance event counter
// Wrapping counter with clear, preload and a sticky flag
// that records a wrap until the next clear.
//############################################################

`timescale 1ns/1ps

module perf_counter (
	input  logic                                      clk,
	input  logic                                      arst_n,
	input  logic                                      inc,
	input  logic                                      clear,
	input  logic                                      load,
	input  logic [core_config_pkg::COUNTER_WIDTH-1:0] load_value,
	output logic [core_config_pkg::COUNTER_WIDTH-1:0] count,
	output logic                                      overflow
);

	logic wrap;	// Increment from all ones

	assign wrap = inc & (&count);

	// Clear, then load, then increment
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			count <= '0;
			overflow <= 1'b0;
		end else if (clear) begin
			count <= '0;
			overflow <= 1'b0;	// Only way to drop the flag
		end else if (load) begin
			count <= load_value;	// Flag kept across a preload
		end else if (inc) begin
			count <= count + 1'b1;	// Wraps to zero
			if (wrap) begin
				overflow <= 1'b1;	// Sticky
			end
		end
	end

endmodule

// File: list.f
hdl/core_config_pkg.sv
hdl/creg_pkg.sv
hdl/perf_counter.sv
hdl/control_registers.sv
hdl/creg_read_mux.sv
hdl/core_perf_control.sv
verification/core_perf_control_tb.sv

// File: verification/core_perf_control_tb.sv
//############################################################
// Core control and performance monitor testbench
// Directed tests of thread control, event counting, overflow,
// clear and the registered read path against a small model.
//############################################################

`timescale 1ns/1ps

module core_perf_control_tb;

	localparam int CLK_PERIOD = 20;	// ns
	localparam int RESET_CYCLES = 3;
	localparam int EVENT_CYCLES = 50;	// Random event phase
	localparam int ACCESS_CYCLES = 90;	// Reads, writes and single pulses
	localparam int MARGIN_CYCLES = 100;
	localparam int TIMEOUT_NS =
		(RESET_CYCLES + EVENT_CYCLES + ACCESS_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

	logic        clk;
	logic        arst_n;
	logic [7:0]  perf_event;
	logic        creg_write_en;
	logic        creg_read_en;
	creg_pkg::control_register_t creg_index;
	logic [31:0] creg_write_val;
	logic [31:0] creg_read_val;
	logic        creg_read_valid;
	logic [3:0]  thread_enable;
	logic        processor_halt;

	integer      seed = 27267;	// Event pattern seed
	logic        read_pending = 1'b0;	// Read strobe seen at last edge
	logic [3:0]  exp_threads = 4'b0001;	// Expected register state
	logic [7:0]  exp_enable = 8'hFF;
	logic [7:0]  exp_overflow = 8'h00;
	logic [15:0] exp_count [8];

	core_perf_control #(
		.core_id (5)
	) dut_i (
		.clk             (clk),
		.arst_n          (arst_n),
		.perf_event      (perf_event),
		.creg_write_en   (creg_write_en),
		.creg_read_en    (creg_read_en),
		.creg_index      (creg_index),
		.creg_write_val  (creg_write_val),
		.creg_read_val   (creg_read_val),
		.creg_read_valid (creg_read_valid),
		.thread_enable   (thread_enable),
		.processor_halt  (processor_halt)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Run did not finish within %0d ns, a DUT response never came", TIMEOUT_NS);
		$display("Errors found");
		$fatal(1, "watchdog expired");
	end

	// Valid must follow each read strobe by exactly one edge
	always @(posedge clk) read_pending <= creg_read_en;

	always @(negedge clk) begin
		if (creg_read_valid !== read_pending) begin
			if (read_pending) begin
				$display("At %0t ns creg_read_valid is missing after a read strobe", $time);
			end else begin
				$display("At %0t ns creg_read_valid is high without a read strobe", $time);
			end
			$display("Errors found");
			$fatal(1, "read valid protocol broken");
		end
	end

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("mismatch at %0t ns: %s, got 0x%0h, expected 0x%0h",
				$time, what, actual, expected);
			$display("Errors found");
			$fatal(1, "stopped at first error");
		end
	endtask

	function automatic creg_pkg::control_register_t counter_index(input int n);
		return creg_pkg::control_register_t'(creg_pkg::CR_PERF_COUNT0 + n);	// Consecutive codes
	endfunction

	// Expected register state after a write
	task automatic apply_write(input creg_pkg::control_register_t index, input logic [31:0] val);
		case (index)
			creg_pkg::CR_THREAD_RESUME: exp_threads = exp_threads | val[3:0];
			creg_pkg::CR_THREAD_HALT: exp_threads = exp_threads & ~val[3:0];
			creg_pkg::CR_PERF_ENABLE: exp_enable = val[7:0];
			creg_pkg::CR_PERF_CLEAR: begin
				for (int i = 0; i < 8; i++) begin
					if (val[i]) begin
						exp_count[i] = '0;
						exp_overflow[i] = 1'b0;	// Clear drops the flag
					end
				end
			end
			default: begin
				if (index >= creg_pkg::CR_PERF_COUNT0 && index <= creg_pkg::CR_PERF_COUNT7) begin
					exp_count[index - creg_pkg::CR_PERF_COUNT0] = val[15:0];	// Preload
				end
			end
		endcase
	endtask

	task automatic write_reg(input creg_pkg::control_register_t index, input logic [31:0] val);
		creg_write_en = 1'b1;
		creg_index = index;
		creg_write_val = val;
		@(posedge clk);
		#2;
		creg_write_en = 1'b0;
		apply_write(index, val);
	endtask

	task automatic read_reg(input creg_pkg::control_register_t index, input logic [31:0] expected,
			input string what);
		creg_read_en = 1'b1;
		creg_index = index;
		@(posedge clk);
		#2;
		creg_read_en = 1'b0;
		check_value(creg_read_valid, 1'b1, {what, ", read valid"});
		check_value(creg_read_val, expected, what);
	endtask

	// Read and write strobes share an edge and the read sees the old value
	task automatic write_and_read(input creg_pkg::control_register_t index,
			input logic [31:0] val, input logic [31:0] old_val);
		creg_write_en = 1'b1;
		creg_read_en = 1'b1;
		creg_index = index;
		creg_write_val = val;
		@(posedge clk);
		#2;
		creg_write_en = 1'b0;
		creg_read_en = 1'b0;
		apply_write(index, val);
		check_value(creg_read_valid, 1'b1, "overlapped read valid");
		check_value(creg_read_val, old_val, "overlapped read returns old value");
		@(posedge clk);
		#2;
		check_value(creg_read_valid, 1'b0, "read valid lasts one cycle");
	endtask

	// One cycle of event pulses counted only where enabled
	task automatic pulse_events(input logic [7:0] pattern);
		perf_event = pattern;
		for (int i = 0; i < 8; i++) begin
			if (pattern[i] && exp_enable[i]) begin
				if (exp_count[i] == 16'hFFFF) exp_overflow[i] = 1'b1;	// Wrap
				exp_count[i] = exp_count[i] + 16'd1;
			end
		end
		@(posedge clk);
		#2;
		perf_event = '0;
	endtask

	task automatic check_threads(input string what);
		check_value(thread_enable, exp_threads, {what, ", thread_enable"});
		check_value(processor_halt, exp_threads == 4'b0000, {what, ", processor_halt"});
	endtask

	task automatic after_reset_values();
		read_reg(creg_pkg::CR_CORE_ID, 32'd5, "core ID");
		read_reg(creg_pkg::CR_THREAD_ENABLE, 32'h1, "thread enable after reset");
		read_reg(creg_pkg::CR_PERF_ENABLE, 32'hFF, "counter enable after reset");
		for (int i = 0; i < 8; i++) begin
			read_reg(counter_index(i), 32'd0, $sformatf("counter %0d after reset", i));
		end
		read_reg(creg_pkg::CR_PERF_OVERFLOW, 32'd0, "overflow after reset");
		check_value(processor_halt, 1'b0, "processor_halt after reset");
	endtask

	task automatic thread_resume_halt();
		write_reg(creg_pkg::CR_THREAD_RESUME, 32'h6);
		check_threads("resume threads 1 and 2");
		read_reg(creg_pkg::CR_THREAD_ENABLE, 32'h7, "thread enable after resume");
		write_reg(creg_pkg::CR_THREAD_HALT, 32'h3);
		check_threads("halt threads 0 and 1");
		write_reg(creg_pkg::CR_THREAD_HALT, 32'h4);	// Last running thread
		check_threads("halt thread 2");
		read_reg(creg_pkg::CR_THREAD_ENABLE, 32'h0, "thread enable all halted");
		write_reg(creg_pkg::CR_THREAD_RESUME, 32'h1);
		check_threads("resume thread 0");
	endtask

	task automatic random_event_counts();
		logic [31:0] ev;
		write_reg(creg_pkg::CR_PERF_ENABLE, 32'hAD);
		repeat (EVENT_CYCLES / 2) begin
			ev = $random(seed);
			pulse_events(ev[7:0]);
		end
		write_reg(creg_pkg::CR_PERF_ENABLE, 32'h5B);	// Different set disabled
		repeat (EVENT_CYCLES / 2) begin
			ev = $random(seed);
			pulse_events(ev[7:0]);
		end
		write_reg(creg_pkg::CR_PERF_ENABLE, 32'hFF);
		for (int i = 0; i < 8; i++) begin
			read_reg(counter_index(i), exp_count[i], $sformatf("event count %0d", i));
		end
		read_reg(creg_pkg::CR_PERF_OVERFLOW, exp_overflow, "overflow after random events");
	endtask

	task automatic overflow_and_clear();
		write_reg(counter_index(creg_pkg::ICACHE_HIT), 32'hFFFE);
		repeat (3) pulse_events(8'h08);	// FFFE, FFFF, 0, 1
		read_reg(counter_index(creg_pkg::ICACHE_HIT), 32'd1, "counter 3 after wrap");
		read_reg(creg_pkg::CR_PERF_OVERFLOW, 32'h08, "overflow flag after wrap");
		write_reg(creg_pkg::CR_PERF_CLEAR, 32'h08);
		for (int i = 0; i < 8; i++) begin
			read_reg(counter_index(i), exp_count[i], $sformatf("counter %0d after clear", i));
		end
		read_reg(creg_pkg::CR_PERF_OVERFLOW, 32'd0, "overflow after clear");
	endtask

	task automatic read_write_overlap();
		write_and_read(creg_pkg::CR_PERF_ENABLE, 32'h0F, 32'hFF);
		read_reg(creg_pkg::CR_PERF_ENABLE, 32'h0F, "counter enable after overlap");
		read_reg(creg_pkg::control_register_t'(5'd7), 32'd0, "unknown index 7");
		read_reg(creg_pkg::control_register_t'(5'd16), 32'd0, "unknown index 16");
		read_reg(creg_pkg::control_register_t'(5'd31), 32'd0, "unknown index 31");
		read_reg(creg_pkg::CR_THREAD_RESUME, 32'd0, "write only index");
		write_reg(creg_pkg::control_register_t'(5'd20), 32'hFFFF_FFFF);	// Ignored
		read_reg(creg_pkg::CR_PERF_ENABLE, exp_enable, "enable after unknown write");
		read_reg(creg_pkg::CR_THREAD_ENABLE, exp_threads, "threads after unknown write");
	endtask

	initial begin
		arst_n = 1'b0;
		perf_event = '0;
		creg_write_en = 1'b0;
		creg_read_en = 1'b0;
		creg_index = creg_pkg::CR_CORE_ID;
		creg_write_val = '0;
		for (int i = 0; i < 8; i++) exp_count[i] = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#2;
		arst_n = 1'b1;
		after_reset_values();
		thread_resume_halt();
		random_event_counts();
		overflow_and_clear();
		read_write_overlap();
		$display("No errors");
		$finish;
	end

endmodule
